// File: bench/ddr_arb_asserts.sv
// bound into ddr_arb_top, the owner checks assume a client holds req until its finish
module ddr_arb_asserts (
    input logic                             ddr_clk,
    input logic                             ddr_rstn,
    input logic [ddr_arb_pkg::num_ch-1:0]   wr_req,
    input logic [ddr_arb_pkg::num_ch-1:0]   rd_req,
    input logic [ddr_arb_pkg::num_ch-1:0]   wr_valid,
    input logic [ddr_arb_pkg::num_ch-1:0]   rd_valid,
    input logic [ddr_arb_pkg::num_ch-1:0]   wr_finish,
    input logic [ddr_arb_pkg::num_ch-1:0]   rd_finish,
    input logic                             mem_wr_req,
    input logic                             mem_wr_data_req,
    input logic                             mem_wr_finish,
    input logic                             mem_rd_req,
    input logic                             mem_rd_data_valid,
    input logic                             mem_rd_finish,
    input logic                             cfg_req,
    input logic                             cfg_ack
);

    // a beat from the memory reaches exactly one channel
    a_wr_valid_one: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        mem_wr_data_req ? $onehot(wr_valid) : (wr_valid == '0))
        else $error("write beat not routed to exactly one channel");
    a_rd_valid_one: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        mem_rd_data_valid ? $onehot(rd_valid) : (rd_valid == '0))
        else $error("read beat not routed to exactly one channel");
    // the granted client is the one still holding req
    a_wr_fin_owner: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        (wr_finish & ~wr_req) == '0
        && (mem_wr_finish ? $onehot(wr_finish) : (wr_finish == '0)))
        else $error("write finish reached a channel without a grant");
    a_rd_fin_owner: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        (rd_finish & ~rd_req) == '0
        && (mem_rd_finish ? $onehot(rd_finish) : (rd_finish == '0)))
        else $error("read finish reached a channel without a grant");
    a_wr_req_hold: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        mem_wr_req && !mem_wr_finish |=> mem_wr_req) else $error("write burst req dropped early");
    a_rd_req_hold: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        mem_rd_req && !mem_rd_finish |=> mem_rd_req) else $error("read burst req dropped early");
    a_ack_on_req: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        $rose(cfg_ack) |-> cfg_req) else $error("cfg ack rose without req");

endmodule

bind ddr_arb_top ddr_arb_asserts u_asserts (.*);

// File: bench/ddr_arb_tb.sv
// each channel owns a 256-word region, bursts of 1 to 8 words, first grant of a group is free
module ddr_arb_tb;
    import ddr_arb_pkg::*;

    localparam int data_w = def_data_w;
    localparam int addr_w = def_addr_w;
    localparam int len_w  = def_len_w;

    logic ddr_clk, ddr_rstn, cfg_req, cfg_we, cfg_ack;
    logic [1:0] cfg_addr;
    logic [cnt_w-1:0] cfg_wdata, cfg_rdata, rdata;
    logic [num_ch-1:0] wr_req, wr_valid, wr_finish, rd_req, rd_valid, rd_finish;
    logic [num_ch-1:0][addr_w-1:0] wr_addr, rd_addr;
    logic [num_ch-1:0][len_w-1:0] wr_len, rd_len;
    logic [num_ch-1:0][data_w-1:0] wr_data;
    logic [data_w-1:0] rd_data;
    logic [data_w-1:0] shadow [2**addr_w];
    logic [data_w-1:0] words [num_ch][8];
    logic [addr_w-1:0] keep_addr [num_ch];
    logic [len_w-1:0] keep_len [num_ch];
    logic [num_ch-1:0] en_wr;
    logic [31:0] seed;
    int wr_beat [num_ch];
    int rd_beat [num_ch];
    int errors, wr_fins, rd_fins, cycles, limit, last_wr, last_rd;
    bit wr_first, rd_first;

    ddr_arb_top u_dut (.*);

    always #4 ddr_clk = ~ddr_clk;

    // galois lfsr, one step per bit taken
    function automatic logic [data_w-1:0] rand_bits(input int n);
        logic [data_w-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[data_w-2:0], seed[0]};
            seed = seed[0] ? ((seed >> 1) ^ 32'ha300_0000) : (seed >> 1);
        end
        return v;
    endfunction

    // next grant: first requesting and enabled channel after the last one served
    function automatic int next_grant(input int last, input logic [3:0] req, input logic [3:0] en);
        int ch;
        for (int k = 1; k <= num_ch; k++) begin
            ch = (last + k) % num_ch;
            if (req[ch] && en[ch]) return ch;
        end
        return -1;
    endfunction

    function automatic logic [data_w-1:0] expected_word(input logic [addr_w-1:0] a);
        return shadow[a];
    endfunction

    task automatic expect_eq(input logic [data_w-1:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic launch_wr(input int c, input int base);
        logic [len_w-1:0] len;
        logic [addr_w-1:0] a;
        len = len_w'(rand_bits(3)) + 1'b1;
        a = addr_w'(c * 256 + base) + addr_w'(rand_bits(6));
        // word i of the burst lands at a + i
        for (int i = 0; i < len; i++) begin
            words[c][i] = rand_bits(data_w);
            shadow[a + addr_w'(i)] = words[c][i];
        end
        if (base == 0) begin
            keep_addr[c] = a;
            keep_len[c] = len;
        end
        wr_first = (wr_req == '0);
        wr_beat[c] = 0;
        wr_addr[c] <= a;
        wr_len[c] <= len;
        wr_data[c] <= words[c][0];
        wr_req[c] <= 1'b1;
        limit += 4 * len + 40;
    endtask

    task automatic launch_rd(input int c);
        rd_first = (rd_req == '0);
        rd_beat[c] = 0;
        rd_addr[c] <= keep_addr[c];
        rd_len[c] <= keep_len[c];
        rd_req[c] <= 1'b1;
        limit += 4 * keep_len[c] + 40;
    endtask

    task automatic wait_idle();
        do @(posedge ddr_clk); while (wr_req != '0 || rd_req != '0);
    endtask

    task automatic cfg_access(input logic we, input logic [1:0] a, input logic [cnt_w-1:0] d,
                              output logic [cnt_w-1:0] q);
        @(posedge ddr_clk);
        cfg_req <= 1'b1;
        cfg_we <= we;
        cfg_addr <= a;
        cfg_wdata <= d;
        do @(posedge ddr_clk); while (!cfg_ack);
        q = cfg_rdata;
        cfg_req <= 1'b0;
        do @(posedge ddr_clk); while (cfg_ack);
    endtask

    // client model and compare process
    always @(posedge ddr_clk) begin
        if (ddr_rstn) begin
            for (int c = 0; c < num_ch; c++) begin
                if ((wr_valid[c] && !wr_req[c]) || (rd_valid[c] && !rd_req[c])) begin
                    errors++;
                    $display("Fail %0t: valid on idle channel %0d", $time, c);
                end
                if (wr_valid[c]) begin
                    wr_beat[c]++;
                    wr_data[c] <= words[c][wr_beat[c] % 8];
                end
                if (rd_valid[c]) begin
                    expect_eq(rd_data, expected_word(rd_addr[c] + addr_w'(rd_beat[c])),
                              "read beat");
                    rd_beat[c]++;
                end
                if (wr_finish[c]) begin
                    if (!en_wr[c] || (!wr_first && c != next_grant(last_wr, wr_req, en_wr))) begin
                        errors++;
                        $display("Fail %0t: write finish out of order on channel %0d", $time, c);
                    end
                    expect_eq(wr_beat[c], wr_len[c], "write beat count");
                    wr_first = 0;
                    last_wr = c;
                    wr_fins++;
                    wr_req[c] <= 1'b0;
                end
                if (rd_finish[c]) begin
                    if (!rd_first && c != next_grant(last_rd, rd_req, 4'hf)) begin
                        errors++;
                        $display("Fail %0t: read finish out of order on channel %0d", $time, c);
                    end
                    expect_eq(rd_beat[c], rd_len[c], "read beat count");
                    rd_first = 0;
                    last_rd = c;
                    rd_fins++;
                    rd_req[c] <= 1'b0;
                end
            end
        end
    end

    always @(posedge ddr_clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles with requests still pending", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        ddr_clk = 0;
        ddr_rstn = 0;
        {cfg_req, cfg_we, cfg_addr, cfg_wdata} = '0;
        {wr_req, wr_addr, wr_len, wr_data} = '0;
        {rd_req, rd_addr, rd_len} = '0;
        seed = 32'h91d2_0c0f;
        en_wr = 4'hf;
        {errors, wr_fins, rd_fins, cycles, last_wr, last_rd} = '0;
        limit = 200;
        repeat (5) @(posedge ddr_clk);
        ddr_rstn <= 1'b1;
        @(posedge ddr_clk);
        expect_eq({wr_valid, wr_finish, rd_valid, rd_finish, cfg_ack}, '0, "outputs after reset");
        for (int r = 0; r < 4; r++) begin
            cfg_access(1'b0, 2'(r), '0, rdata);
            expect_eq(rdata, (r < 2) ? 16'h000f : 16'h0000, "register after reset");
        end
        for (int c = 0; c < num_ch; c++) begin
            @(posedge ddr_clk);
            launch_wr(c, 0);
            wait_idle();
            @(posedge ddr_clk);
            launch_rd(c);
            wait_idle();
        end
        // new writes go to a separate part of each region while reads run
        @(posedge ddr_clk);
        for (int c = 0; c < num_ch; c++) launch_wr(c, 128);
        for (int c = 0; c < num_ch; c++) launch_rd(c);
        wait_idle();
        cfg_access(1'b1, reg_wr_en, 16'h000b, rdata);
        en_wr = 4'hb;
        @(posedge ddr_clk);
        for (int c = 0; c < num_ch; c++) launch_wr(c, 64);
        do @(posedge ddr_clk); while (wr_req != 4'b0100);
        repeat (30) @(posedge ddr_clk);
        if (!wr_req[2]) begin
            errors++;
            $display("disabled write channel 2 completed a burst");
        end
        cfg_access(1'b1, reg_wr_en, 16'h000f, rdata);
        en_wr = 4'hf;
        wait_idle();
        repeat (4) @(posedge ddr_clk);
        cfg_access(1'b0, reg_wr_cnt, '0, rdata);
        expect_eq(rdata, wr_fins, "write burst counter");
        cfg_access(1'b0, reg_rd_cnt, '0, rdata);
        expect_eq(rdata, rd_fins, "read burst counter");
        cfg_access(1'b1, reg_wr_cnt, '0, rdata);
        cfg_access(1'b1, reg_rd_cnt, '0, rdata);
        cfg_access(1'b0, reg_wr_cnt, '0, rdata);
        expect_eq(rdata, 0, "cleared write counter");
        cfg_access(1'b0, reg_rd_cnt, '0, rdata);
        expect_eq(rdata, 0, "cleared read counter");
        $display("errors %0d, write finishes %0d, read finishes %0d", errors, wr_fins, rd_fins);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: ddr_arb.f
source/ddr_arb_pkg.sv
source/arb_cfg_regs.sv
source/burst_rr_arb.sv
source/burst_mem.sv
source/ddr_arb_top.sv
bench/ddr_arb_asserts.sv
bench/ddr_arb_tb.sv

// File: source/arb_cfg_regs.sv
// four-phase port, the outside must see ack low before raising a new req
module arb_cfg_regs (
    input  logic                            ddr_clk,
    input  logic                            ddr_rstn,
    input  logic                            cfg_req,
    input  logic                            cfg_we,
    input  logic [1:0]                      cfg_addr,
    input  logic [ddr_arb_pkg::cnt_w-1:0]   cfg_wdata,
    output logic                            cfg_ack,
    output logic [ddr_arb_pkg::cnt_w-1:0]   cfg_rdata,
    output logic [ddr_arb_pkg::num_ch-1:0]  wr_ch_en,
    output logic [ddr_arb_pkg::num_ch-1:0]  rd_ch_en,
    input  logic                            wr_done,
    input  logic                            rd_done
);
    import ddr_arb_pkg::*;

    logic             access;
    logic             wr_cnt_clr;
    logic             rd_cnt_clr;
    logic [cnt_w-1:0] wr_cnt;
    logic [cnt_w-1:0] rd_cnt;

    // one access per req, on the cycle before ack rises
    assign access     = cfg_req && !cfg_ack;
    assign wr_cnt_clr = access && cfg_we && (cfg_addr == reg_wr_cnt);
    assign rd_cnt_clr = access && cfg_we && (cfg_addr == reg_rd_cnt);

    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            cfg_ack  <= 1'b0;
            wr_ch_en <= '1;
            rd_ch_en <= '1;
            wr_cnt   <= '0;
            rd_cnt   <= '0;
        end else begin
            cfg_ack <= cfg_req;
            if (access && cfg_we && cfg_addr == reg_wr_en) begin
                wr_ch_en <= cfg_wdata[num_ch-1:0];
            end
            if (access && cfg_we && cfg_addr == reg_rd_en) begin
                rd_ch_en <= cfg_wdata[num_ch-1:0];
            end
            // clear wins over a done in the same cycle
            wr_cnt <= wr_cnt_clr ? '0 : wr_cnt + cnt_w'(wr_done);
            rd_cnt <= rd_cnt_clr ? '0 : rd_cnt + cnt_w'(rd_done);
        end
    end

    always_ff @(posedge ddr_clk) begin
        if (access) begin
            case (cfg_addr)
                reg_wr_en:  cfg_rdata <= cnt_w'(wr_ch_en);
                reg_rd_en:  cfg_rdata <= cnt_w'(rd_ch_en);
                reg_wr_cnt: cfg_rdata <= wr_cnt;
                default:    cfg_rdata <= rd_cnt;
            endcase
        end
    end

endmodule

// File: source/burst_mem.sv
// behavioral stand-in with no ddr timing, a burst length of zero is not supported
module burst_mem #(
    parameter int data_w = ddr_arb_pkg::def_data_w,
    parameter int addr_w = ddr_arb_pkg::def_addr_w,
    parameter int len_w  = ddr_arb_pkg::def_len_w
) (
    input  logic               ddr_clk,
    input  logic               ddr_rstn,
    input  logic               mem_wr_req,
    input  logic [addr_w-1:0]  mem_wr_addr,
    input  logic [len_w-1:0]   mem_wr_len,
    input  logic [data_w-1:0]  mem_wr_data,
    output logic               mem_wr_data_req,
    output logic               mem_wr_finish,
    input  logic               mem_rd_req,
    input  logic [addr_w-1:0]  mem_rd_addr,
    input  logic [len_w-1:0]   mem_rd_len,
    output logic [data_w-1:0]  mem_rd_data,
    output logic               mem_rd_data_valid,
    output logic               mem_rd_finish
);

    typedef enum logic [1:0] {
        eng_idle,
        eng_wait,
        eng_beat,
        eng_fin
    } eng_state_t;

    logic [data_w-1:0]  mem [2**addr_w];
    // engine 0 serves writes, engine 1 reads
    eng_state_t         eng_st   [2];
    logic [addr_w-1:0]  req_addr [2];
    logic [len_w-1:0]   req_len  [2];
    logic [addr_w-1:0]  ptr      [2];
    logic [len_w-1:0]   left     [2];
    logic [1:0]         req;
    logic [1:0]         armed;
    logic [1:0]         accept;

    assign req         = {mem_rd_req, mem_wr_req};
    assign req_addr[0] = mem_wr_addr;
    assign req_addr[1] = mem_rd_addr;
    assign req_len[0]  = mem_wr_len;
    assign req_len[1]  = mem_rd_len;

    // a new burst needs req to have dropped since the last finish
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            accept[d] = (eng_st[d] == eng_idle) && req[d] && armed[d];
        end
    end

    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            eng_st[0] <= eng_idle;
            eng_st[1] <= eng_idle;
            armed     <= '0;
        end else begin
            for (int d = 0; d < 2; d++) begin
                if (!req[d]) begin
                    armed[d] <= 1'b1;
                end else if (accept[d]) begin
                    armed[d] <= 1'b0;
                end
                case (eng_st[d])
                    eng_idle: eng_st[d] <= accept[d] ? eng_wait : eng_idle;
                    eng_wait: eng_st[d] <= eng_beat;
                    eng_beat: eng_st[d] <= (left[d] == len_w'(1)) ? eng_fin : eng_beat;
                    default:  eng_st[d] <= eng_idle;
                endcase
            end
        end
    end

    always_ff @(posedge ddr_clk) begin
        for (int d = 0; d < 2; d++) begin
            if (accept[d]) begin
                ptr[d]  <= req_addr[d];
                left[d] <= req_len[d];
            end else if (eng_st[d] == eng_beat) begin
                ptr[d]  <= ptr[d] + 1'b1;
                left[d] <= left[d] - 1'b1;
            end
        end
        if (eng_st[0] == eng_beat) begin
            mem[ptr[0]] <= mem_wr_data;
        end
    end

    assign mem_wr_data_req   = (eng_st[0] == eng_beat);
    assign mem_wr_finish     = (eng_st[0] == eng_fin);
    assign mem_rd_data_valid = (eng_st[1] == eng_beat);
    assign mem_rd_finish     = (eng_st[1] == eng_fin);
    // beat data comes out with valid
    assign mem_rd_data       = mem[ptr[1]];

endmodule

// File: source/burst_rr_arb.sv
// one burst in flight per direction, clients hold req, addr and len until their finish
module burst_rr_arb #(
    parameter int data_w = ddr_arb_pkg::def_data_w,
    parameter int addr_w = ddr_arb_pkg::def_addr_w,
    parameter int len_w  = ddr_arb_pkg::def_len_w
) (
    input  logic                                        ddr_clk,
    input  logic                                        ddr_rstn,
    // write clients
    input  logic [ddr_arb_pkg::num_ch-1:0]              wr_req,
    input  logic [ddr_arb_pkg::num_ch-1:0][addr_w-1:0]  wr_addr,
    input  logic [ddr_arb_pkg::num_ch-1:0][len_w-1:0]   wr_len,
    input  logic [ddr_arb_pkg::num_ch-1:0][data_w-1:0]  wr_data,
    output logic [ddr_arb_pkg::num_ch-1:0]              wr_valid,
    output logic [ddr_arb_pkg::num_ch-1:0]              wr_finish,
    // read clients
    input  logic [ddr_arb_pkg::num_ch-1:0]              rd_req,
    input  logic [ddr_arb_pkg::num_ch-1:0][addr_w-1:0]  rd_addr,
    input  logic [ddr_arb_pkg::num_ch-1:0][len_w-1:0]   rd_len,
    output logic [data_w-1:0]                           rd_data,
    output logic [ddr_arb_pkg::num_ch-1:0]              rd_valid,
    output logic [ddr_arb_pkg::num_ch-1:0]              rd_finish,
    // burst port
    output logic                                        mem_wr_req,
    output logic [addr_w-1:0]                           mem_wr_addr,
    output logic [len_w-1:0]                            mem_wr_len,
    output logic [data_w-1:0]                           mem_wr_data,
    input  logic                                        mem_wr_data_req,
    input  logic                                        mem_wr_finish,
    output logic                                        mem_rd_req,
    output logic [addr_w-1:0]                           mem_rd_addr,
    output logic [len_w-1:0]                            mem_rd_len,
    input  logic [data_w-1:0]                           mem_rd_data,
    input  logic                                        mem_rd_data_valid,
    input  logic                                        mem_rd_finish,
    // config block
    input  logic [ddr_arb_pkg::num_ch-1:0]              wr_ch_en,
    input  logic [ddr_arb_pkg::num_ch-1:0]              rd_ch_en,
    output logic                                        wr_done,
    output logic                                        rd_done
);
    import ddr_arb_pkg::*;

    // index 0 is the write direction, 1 the read direction
    logic [num_ch-1:0]              ch_req     [2];
    logic [num_ch-1:0]              ch_en      [2];
    logic [num_ch-1:0][addr_w-1:0]  ch_addr    [2];
    logic [num_ch-1:0][len_w-1:0]   ch_len     [2];
    arb_state_t                     state      [2];
    logic [num_ch-1:0]              grant      [2];
    logic [num_ch-1:0]              grant_d    [2];
    logic [addr_w-1:0]              burst_addr [2];
    logic [len_w-1:0]               burst_len  [2];
    logic [1:0]                     burst_req;
    logic [1:0]                     bus_fin;
    logic [1:0]                     hit;
    logic [1:0]                     done;

    assign ch_req[0]  = wr_req;
    assign ch_req[1]  = rd_req;
    assign ch_en[0]   = wr_ch_en;
    assign ch_en[1]   = rd_ch_en;
    assign ch_addr[0] = wr_addr;
    assign ch_addr[1] = rd_addr;
    assign ch_len[0]  = wr_len;
    assign ch_len[1]  = rd_len;
    assign bus_fin    = {mem_rd_finish, mem_wr_finish};

    // visited channel is requesting and enabled
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            hit[d] = state[d][2] && !state[d][3]
                     && ch_req[d][state[d][1:0]] && ch_en[d][state[d][1:0]];
        end
    end

    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            for (int d = 0; d < 2; d++) begin
                state[d]   <= st_idle;
                grant[d]   <= '0;
                grant_d[d] <= '0;
            end
            burst_req <= '0;
            done      <= '0;
        end else begin
            for (int d = 0; d < 2; d++) begin
                grant_d[d] <= grant[d];
                done[d]    <= bus_fin[d] && state[d][3];
                if (!state[d][2]) begin
                    state[d] <= st_visit0;
                end else if (!state[d][3]) begin
                    if (hit[d]) begin
                        state[d]     <= arb_state_t'({2'b11, state[d][1:0]});
                        grant[d]     <= num_ch'(1) << state[d][1:0];
                        burst_req[d] <= 1'b1;
                    end else begin
                        state[d] <= arb_state_t'({2'b01, state[d][1:0] + 2'd1});
                    end
                end else if (bus_fin[d]) begin
                    // burst over, move on to the next channel
                    state[d]     <= arb_state_t'({2'b01, state[d][1:0] + 2'd1});
                    grant[d]     <= '0;
                    burst_req[d] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ddr_clk) begin
        for (int d = 0; d < 2; d++) begin
            if (hit[d]) begin
                burst_addr[d] <= ch_addr[d][state[d][1:0]];
                burst_len[d]  <= ch_len[d][state[d][1:0]];
            end
        end
    end

    assign mem_wr_req  = burst_req[0];
    assign mem_wr_addr = burst_addr[0];
    assign mem_wr_len  = burst_len[0];
    assign mem_rd_req  = burst_req[1];
    assign mem_rd_addr = burst_addr[1];
    assign mem_rd_len  = burst_len[1];
    assign wr_done     = done[0];
    assign rd_done     = done[1];

    // steering uses the delayed grant
    always_comb begin
        mem_wr_data = '0;
        for (int c = 0; c < num_ch; c++) begin
            if (grant_d[0][c]) begin
                mem_wr_data = wr_data[c];
            end
        end
    end

    assign wr_valid  = grant_d[0] & {num_ch{mem_wr_data_req}};
    assign wr_finish = grant_d[0] & {num_ch{mem_wr_finish}};
    assign rd_valid  = grant_d[1] & {num_ch{mem_rd_data_valid}};
    assign rd_finish = grant_d[1] & {num_ch{mem_rd_finish}};
    assign rd_data   = mem_rd_data;

endmodule

// File: source/ddr_arb_pkg.sv
// num_ch must stay 4 because the arbiter visit order is built for four channels
package ddr_arb_pkg;

    localparam int num_ch     = 4;
    localparam int def_data_w = 128;
    localparam int def_addr_w = 10;
    localparam int def_len_w  = 8;
    localparam int cnt_w      = 16;

    // config register offsets
    localparam logic [1:0] reg_wr_en  = 2'd0;
    localparam logic [1:0] reg_rd_en  = 2'd1;
    localparam logic [1:0] reg_wr_cnt = 2'd2;
    localparam logic [1:0] reg_rd_cnt = 2'd3;

    // bit 3 serving, bit 2 active, bits 1:0 channel
    typedef enum logic [3:0] {
        st_idle   = 4'b0000,
        st_visit0 = 4'b0100,
        st_visit1 = 4'b0101,
        st_visit2 = 4'b0110,
        st_visit3 = 4'b0111,
        st_serve0 = 4'b1100,
        st_serve1 = 4'b1101,
        st_serve2 = 4'b1110,
        st_serve3 = 4'b1111
    } arb_state_t;

endpackage

// File: source/ddr_arb_top.sv
// widths default to the package values, read data is shared by all read channels
module ddr_arb_top #(
    parameter int data_w = ddr_arb_pkg::def_data_w,
    parameter int addr_w = ddr_arb_pkg::def_addr_w,
    parameter int len_w  = ddr_arb_pkg::def_len_w
) (
    input  logic                                        ddr_clk,
    input  logic                                        ddr_rstn,
    input  logic [ddr_arb_pkg::num_ch-1:0]              wr_req,
    input  logic [ddr_arb_pkg::num_ch-1:0][addr_w-1:0]  wr_addr,
    input  logic [ddr_arb_pkg::num_ch-1:0][len_w-1:0]   wr_len,
    input  logic [ddr_arb_pkg::num_ch-1:0][data_w-1:0]  wr_data,
    output logic [ddr_arb_pkg::num_ch-1:0]              wr_valid,
    output logic [ddr_arb_pkg::num_ch-1:0]              wr_finish,
    input  logic [ddr_arb_pkg::num_ch-1:0]              rd_req,
    input  logic [ddr_arb_pkg::num_ch-1:0][addr_w-1:0]  rd_addr,
    input  logic [ddr_arb_pkg::num_ch-1:0][len_w-1:0]   rd_len,
    output logic [data_w-1:0]                           rd_data,
    output logic [ddr_arb_pkg::num_ch-1:0]              rd_valid,
    output logic [ddr_arb_pkg::num_ch-1:0]              rd_finish,
    input  logic                                        cfg_req,
    input  logic                                        cfg_we,
    input  logic [1:0]                                  cfg_addr,
    input  logic [ddr_arb_pkg::cnt_w-1:0]               cfg_wdata,
    output logic                                        cfg_ack,
    output logic [ddr_arb_pkg::cnt_w-1:0]               cfg_rdata
);
    import ddr_arb_pkg::*;

    logic [num_ch-1:0]  wr_ch_en;
    logic [num_ch-1:0]  rd_ch_en;
    logic               wr_done;
    logic               rd_done;
    logic               mem_wr_req;
    logic [addr_w-1:0]  mem_wr_addr;
    logic [len_w-1:0]   mem_wr_len;
    logic [data_w-1:0]  mem_wr_data;
    logic               mem_wr_data_req;
    logic               mem_wr_finish;
    logic               mem_rd_req;
    logic [addr_w-1:0]  mem_rd_addr;
    logic [len_w-1:0]   mem_rd_len;
    logic [data_w-1:0]  mem_rd_data;
    logic               mem_rd_data_valid;
    logic               mem_rd_finish;

    arb_cfg_regs u_cfg (.*);

    burst_rr_arb #(
        .data_w (data_w),
        .addr_w (addr_w),
        .len_w  (len_w)
    ) u_arb (.*);

    burst_mem #(
        .data_w (data_w),
        .addr_w (addr_w),
        .len_w  (len_w)
    ) u_mem (.*);

endmodule
